//--- include/fabric_settings.svh
`ifndef FABRIC_SETTINGS_SVH
`define FABRIC_SETTINGS_SVH

// Cluster count and the bits needed to name one cluster
`define FABRIC_NUM_CLUSTERS      4
`define FABRIC_CLUSTER_ID_WIDTH  2

// I/O word channel
`define FABRIC_ADDR_WIDTH        30
`define FABRIC_DATA_WIDTH        32
`define FABRIC_BYTEEN_WIDTH      4

// Tag a cluster puts on its own I/O requests
`define FABRIC_CORE_TAG_WIDTH    8

// Snoop channel, line granular
`define FABRIC_SNP_ADDR_WIDTH    26
`define FABRIC_SNP_TAG_WIDTH     6

`endif

//--- design/fabric_pkg.sv
`include "fabric_settings.svh"

package fabric_pkg;

    // One bit per cluster
    typedef logic [`FABRIC_NUM_CLUSTERS-1:0] cluster_mask_t;

    typedef struct packed {
        logic                              rw;
        logic [`FABRIC_BYTEEN_WIDTH-1:0]   byteen;
        logic [`FABRIC_ADDR_WIDTH-1:0]     addr;
        logic [`FABRIC_DATA_WIDTH-1:0]     data;
        logic [`FABRIC_CORE_TAG_WIDTH-1:0] tag;
    } io_req_t;

    // Tag carries the cluster index above the core tag
    typedef struct packed {
        logic                              rw;
        logic [`FABRIC_BYTEEN_WIDTH-1:0]   byteen;
        logic [`FABRIC_ADDR_WIDTH-1:0]     addr;
        logic [`FABRIC_DATA_WIDTH-1:0]     data;
        logic [`FABRIC_CLUSTER_ID_WIDTH+`FABRIC_CORE_TAG_WIDTH-1:0] tag;
    } io_req_out_t;

    typedef struct packed {
        logic [`FABRIC_DATA_WIDTH-1:0]     data;
        logic [`FABRIC_CORE_TAG_WIDTH-1:0] tag;
    } io_rsp_t;

    typedef struct packed {
        logic [`FABRIC_DATA_WIDTH-1:0]     data;
        logic [`FABRIC_CLUSTER_ID_WIDTH+`FABRIC_CORE_TAG_WIDTH-1:0] tag;
    } io_rsp_out_t;

    typedef struct packed {
        logic [`FABRIC_SNP_ADDR_WIDTH-1:0] addr;
        logic                              invalidate;
        logic [`FABRIC_SNP_TAG_WIDTH-1:0]  tag;
    } snp_req_t;

endpackage

//--- design/io_arbiter.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module io_arbiter (
    input  logic                                          clk,
    input  logic                                          reset,

    input  fabric_pkg::cluster_mask_t                     in_req_valid,
    input  fabric_pkg::io_req_t [`FABRIC_NUM_CLUSTERS-1:0] in_req,
    output fabric_pkg::cluster_mask_t                     in_req_ready,

    output fabric_pkg::cluster_mask_t                     in_rsp_valid,
    output fabric_pkg::io_rsp_t                           in_rsp,
    input  fabric_pkg::cluster_mask_t                     in_rsp_ready,

    output logic                                          out_req_valid,
    output fabric_pkg::io_req_out_t                       out_req,
    input  logic                                          out_req_ready,

    input  logic                                          out_rsp_valid,
    input  fabric_pkg::io_rsp_out_t                       out_rsp,
    output logic                                          out_rsp_ready
);
    import fabric_pkg::*;

    localparam int NUM   = `FABRIC_NUM_CLUSTERS;
    localparam int ID_W  = `FABRIC_CLUSTER_ID_WIDTH;
    localparam int TAG_W = `FABRIC_CORE_TAG_WIDTH;

    logic [ID_W-1:0] rr_ptr;
    logic [ID_W-1:0] grant_idx;
    logic            grant_found;
    logic [ID_W-1:0] rsp_idx;

    // First valid cluster at or after the pointer, wrapping
    always_comb begin
        int slot;
        slot        = 0;
        grant_found = 1'b0;
        grant_idx   = rr_ptr;
        for (int off = 0; off < NUM; off++) begin
            slot = int'(rr_ptr) + off;
            if (slot >= NUM) begin
                slot = slot - NUM;
            end
            if (!grant_found && in_req_valid[slot]) begin
                grant_found = 1'b1;
                grant_idx   = ID_W'(slot);
            end
        end
    end

    always_comb begin
        out_req.rw     = in_req[grant_idx].rw;
        out_req.byteen = in_req[grant_idx].byteen;
        out_req.addr   = in_req[grant_idx].addr;
        out_req.data   = in_req[grant_idx].data;
        out_req.tag    = {grant_idx, in_req[grant_idx].tag};
    end

    assign out_req_valid = grant_found;
    assign in_req_ready  = (grant_found && out_req_ready) ?
                           (cluster_mask_t'(1) << grant_idx) : '0;

    // Pointer only moves on a transfer, so a stalled grant stays put
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
        end else if (out_req_valid && out_req_ready) begin
            if (grant_idx == ID_W'(NUM - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= grant_idx + 1'b1;
            end
        end
    end

    // Response goes back to the cluster named in the upper tag bits
    assign rsp_idx       = out_rsp.tag[TAG_W +: ID_W];
    assign in_rsp_valid  = out_rsp_valid ? (cluster_mask_t'(1) << rsp_idx) : '0;
    assign in_rsp.data   = out_rsp.data;
    assign in_rsp.tag    = out_rsp.tag[TAG_W-1:0];
    assign out_rsp_ready = in_rsp_ready[rsp_idx];

endmodule

//--- design/snoop_rsp_counter.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module snoop_rsp_counter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clear,
    input  fabric_pkg::cluster_mask_t fwd_rsp_valid,
    output fabric_pkg::cluster_mask_t fwd_rsp_ready,
    output logic                      all_answered
);
    import fabric_pkg::*;

    localparam int NUM   = `FABRIC_NUM_CLUSTERS;
    localparam int CNT_W = `FABRIC_CLUSTER_ID_WIDTH + 1;

    cluster_mask_t    answered;
    cluster_mask_t    accepted;
    logic [CNT_W-1:0] answer_cnt;

    // A cluster that already answered is not taken again
    assign fwd_rsp_ready = ~answered;
    assign accepted      = fwd_rsp_valid & fwd_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            answered   <= '0;
            answer_cnt <= '0;
        end else begin
            answered   <= answered | accepted;
            answer_cnt <= answer_cnt + CNT_W'($countones(accepted));
        end
    end

    assign all_answered = (answer_cnt == CNT_W'(NUM));

endmodule

//--- design/snoop_fwd_fsm.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module snoop_fwd_fsm (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              snp_req_valid,
    input  fabric_pkg::snp_req_t              snp_req,
    output logic                              snp_req_ready,

    output logic                              snp_rsp_valid,
    output logic [`FABRIC_SNP_TAG_WIDTH-1:0]  snp_rsp_tag,
    input  logic                              snp_rsp_ready,

    output fabric_pkg::cluster_mask_t         fwd_req_valid,
    output fabric_pkg::snp_req_t              fwd_req,
    input  fabric_pkg::cluster_mask_t         fwd_req_ready,

    input  logic                              all_answered,
    output logic                              counter_clear,
    output logic                              snoop_active
);
    import fabric_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FWD,
        ST_RESP
    } state_t;

    state_t        state_q;
    state_t        state_d;
    snp_req_t      req_q;
    cluster_mask_t sent;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (snp_req_valid) begin
                    state_d = ST_FWD;
                end
            end
            // Broadcast and collect overlap
            ST_FWD: begin
                if ((&sent) && all_answered) begin
                    state_d = ST_RESP;
                end
            end
            ST_RESP: begin
                if (snp_rsp_ready) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
            sent    <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE) begin
                sent <= '0;
            end else if (state_q == ST_FWD) begin
                sent <= sent | (fwd_req_valid & fwd_req_ready);
            end
        end
    end

    // Request payload captured on acceptance
    always_ff @(posedge clk) begin
        if (snp_req_valid && snp_req_ready) begin
            req_q <= snp_req;
        end
    end

    assign snp_req_ready = (state_q == ST_IDLE);
    assign fwd_req_valid = (state_q == ST_FWD) ? ~sent : '0;
    assign fwd_req       = req_q;

    assign snp_rsp_valid = (state_q == ST_RESP);
    assign snp_rsp_tag   = req_q.tag;

    // Leaving respond ends the operation
    assign counter_clear = (state_q == ST_RESP) && snp_rsp_ready;
    assign snoop_active  = (state_q != ST_IDLE);

endmodule

//--- design/vortex_fabric.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module vortex_fabric (
    input  logic                                          clk,
    input  logic                                          reset,

    // Cluster side
    input  fabric_pkg::cluster_mask_t                     cluster_io_req_valid,
    input  fabric_pkg::io_req_t [`FABRIC_NUM_CLUSTERS-1:0] cluster_io_req,
    output fabric_pkg::cluster_mask_t                     cluster_io_req_ready,

    output fabric_pkg::cluster_mask_t                     cluster_io_rsp_valid,
    output fabric_pkg::io_rsp_t                           cluster_io_rsp,
    input  fabric_pkg::cluster_mask_t                     cluster_io_rsp_ready,

    output fabric_pkg::cluster_mask_t                     cluster_snp_req_valid,
    output fabric_pkg::snp_req_t                          cluster_snp_req,
    input  fabric_pkg::cluster_mask_t                     cluster_snp_req_ready,

    input  fabric_pkg::cluster_mask_t                     cluster_snp_rsp_valid,
    output fabric_pkg::cluster_mask_t                     cluster_snp_rsp_ready,

    input  fabric_pkg::cluster_mask_t                     cluster_busy,
    input  fabric_pkg::cluster_mask_t                     cluster_ebreak,

    // External side
    output logic                                          io_req_valid,
    output fabric_pkg::io_req_out_t                       io_req,
    input  logic                                          io_req_ready,

    input  logic                                          io_rsp_valid,
    input  fabric_pkg::io_rsp_out_t                       io_rsp,
    output logic                                          io_rsp_ready,

    input  logic                                          snp_req_valid,
    input  fabric_pkg::snp_req_t                          snp_req,
    output logic                                          snp_req_ready,

    output logic                                          snp_rsp_valid,
    output logic [`FABRIC_SNP_TAG_WIDTH-1:0]              snp_rsp_tag,
    input  logic                                          snp_rsp_ready,

    output logic                                          busy,
    output logic                                          ebreak
);

    logic all_answered;
    logic counter_clear;
    logic snoop_active;

    io_arbiter u_io_arb (
        .clk           (clk),
        .reset         (reset),
        .in_req_valid  (cluster_io_req_valid),
        .in_req        (cluster_io_req),
        .in_req_ready  (cluster_io_req_ready),
        .in_rsp_valid  (cluster_io_rsp_valid),
        .in_rsp        (cluster_io_rsp),
        .in_rsp_ready  (cluster_io_rsp_ready),
        .out_req_valid (io_req_valid),
        .out_req       (io_req),
        .out_req_ready (io_req_ready),
        .out_rsp_valid (io_rsp_valid),
        .out_rsp       (io_rsp),
        .out_rsp_ready (io_rsp_ready)
    );

    snoop_fwd_fsm u_snoop_fsm (
        .clk           (clk),
        .reset         (reset),
        .snp_req_valid (snp_req_valid),
        .snp_req       (snp_req),
        .snp_req_ready (snp_req_ready),
        .snp_rsp_valid (snp_rsp_valid),
        .snp_rsp_tag   (snp_rsp_tag),
        .snp_rsp_ready (snp_rsp_ready),
        .fwd_req_valid (cluster_snp_req_valid),
        .fwd_req       (cluster_snp_req),
        .fwd_req_ready (cluster_snp_req_ready),
        .all_answered  (all_answered),
        .counter_clear (counter_clear),
        .snoop_active  (snoop_active)
    );

    snoop_rsp_counter u_snoop_cnt (
        .clk           (clk),
        .reset         (reset),
        .clear         (counter_clear),
        .fwd_rsp_valid (cluster_snp_rsp_valid),
        .fwd_rsp_ready (cluster_snp_rsp_ready),
        .all_answered  (all_answered)
    );

    // A snoop in flight keeps the fabric busy
    assign busy   = (|cluster_busy) || snoop_active;
    assign ebreak = &cluster_ebreak;

endmodule

//--- sim/fabric_assert.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module fabric_assert (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              io_req_valid,
    input  logic                              io_req_ready,
    input  fabric_pkg::io_req_out_t           io_req,
    input  logic                              snp_rsp_valid,
    input  logic                              snp_rsp_ready,
    input  logic [`FABRIC_SNP_TAG_WIDTH-1:0]  snp_rsp_tag,
    input  logic                              all_answered,
    input  fabric_pkg::cluster_mask_t         cluster_io_rsp_valid
);

    // Stalled request keeps valid and payload
    io_req_hold: assert property (@(posedge clk) disable iff (reset)
        io_req_valid && !io_req_ready |=> io_req_valid && $stable(io_req))
        else $error("external I/O request dropped or changed before ready");

    snp_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        snp_rsp_valid && !snp_rsp_ready |=> snp_rsp_valid && $stable(snp_rsp_tag))
        else $error("snoop response dropped or changed before ready");

    // Response only once every cluster has answered
    snp_rsp_after_answers: assert property (@(posedge clk) disable iff (reset)
        snp_rsp_valid |-> all_answered)
        else $error("snoop response raised before all clusters answered");

    io_rsp_one_target: assert property (@(posedge clk) disable iff (reset)
        $onehot0(cluster_io_rsp_valid))
        else $error("I/O response routed to more than one cluster");

endmodule

bind vortex_fabric fabric_assert u_fabric_assert (
    .clk                  (clk),
    .reset                (reset),
    .io_req_valid         (io_req_valid),
    .io_req_ready         (io_req_ready),
    .io_req               (io_req),
    .snp_rsp_valid        (snp_rsp_valid),
    .snp_rsp_ready        (snp_rsp_ready),
    .snp_rsp_tag          (snp_rsp_tag),
    .all_answered         (all_answered),
    .cluster_io_rsp_valid (cluster_io_rsp_valid)
);

//--- sim/tb_vortex_fabric.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module tb_vortex_fabric;
    import fabric_pkg::*;

    localparam int NUM     = `FABRIC_NUM_CLUSTERS;
    localparam int ID_W    = `FABRIC_CLUSTER_ID_WIDTH;
    localparam int TAG_W   = `FABRIC_CORE_TAG_WIDTH;
    localparam int TIMEOUT = 200;

    logic                   clk;
    logic                   reset;
    cluster_mask_t          cluster_io_req_valid;
    io_req_t [NUM-1:0]      cluster_io_req;
    cluster_mask_t          cluster_io_req_ready;
    cluster_mask_t          cluster_io_rsp_valid;
    io_rsp_t                cluster_io_rsp;
    cluster_mask_t          cluster_io_rsp_ready;
    cluster_mask_t          cluster_snp_req_valid;
    snp_req_t               cluster_snp_req;
    cluster_mask_t          cluster_snp_req_ready;
    cluster_mask_t          cluster_snp_rsp_valid;
    cluster_mask_t          cluster_snp_rsp_ready;
    cluster_mask_t          cluster_busy;
    cluster_mask_t          cluster_ebreak;
    logic                   io_req_valid;
    io_req_out_t            io_req;
    logic                   io_req_ready;
    logic                   io_rsp_valid;
    io_rsp_out_t            io_rsp;
    logic                   io_rsp_ready;
    logic                   snp_req_valid;
    snp_req_t               snp_req;
    logic                   snp_req_ready;
    logic                   snp_rsp_valid;
    logic [`FABRIC_SNP_TAG_WIDTH-1:0] snp_rsp_tag;
    logic                   snp_rsp_ready;
    logic                   busy;
    logic                   ebreak;

    string test_name;
    int    test_errors;
    int    tests_passed;
    int    tests_failed;

    vortex_fabric u_dut (.*);

    always #50 clk = ~clk;

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_eq(string what, logic [63:0] expected, logic [63:0] actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED %s: %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timeout in %s while waiting for %s", test_name, what);
        test_errors++;
    endtask

    task automatic finish_test();
        $display("%-16s %s (%0d errors)", test_name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        test_errors = 0;
    endtask

    function automatic io_req_t random_req();
        io_req_t r;
        r.rw     = 1'($urandom);
        r.byteen = 4'($urandom);
        r.addr   = 30'($urandom);
        r.data   = $urandom;
        r.tag    = 8'($urandom);
        return r;
    endfunction

    task automatic check_reset_state();
        test_name = "reset_state";
        @(negedge clk);
        check_eq("snp_rsp_valid", 64'(0), 64'(snp_rsp_valid));
        check_eq("forward valids", 64'(0), 64'(cluster_snp_req_valid));
        check_eq("snp_req_ready", 64'(1), 64'(snp_req_ready));
        check_eq("io_req_valid", 64'(0), 64'(io_req_valid));
        finish_test();
    endtask

    task automatic drive_single_requests();
        io_req_t req;
        test_name = "single_request";
        for (int k = 0; k < NUM; k++) begin
            tick();
            req                  = random_req();
            cluster_io_req[k]    = req;
            cluster_io_req_valid = cluster_mask_t'(1) << k;
            io_req_ready         = 1'b1;
            @(negedge clk);
            check_eq("io_req_valid", 64'(1), 64'(io_req_valid));
            check_eq("rw", 64'(req.rw), 64'(io_req.rw));
            check_eq("byteen", 64'(req.byteen), 64'(io_req.byteen));
            check_eq("addr", 64'(req.addr), 64'(io_req.addr));
            check_eq("data", 64'(req.data), 64'(io_req.data));
            check_eq("tag", 64'({ID_W'(k), req.tag}), 64'(io_req.tag));
            check_eq("cluster ready", 64'(cluster_mask_t'(1) << k), 64'(cluster_io_req_ready));
        end
        tick();
        cluster_io_req_valid = '0;
        io_req_ready         = 1'b0;
        finish_test();
    endtask

    task automatic exercise_round_robin();
        cluster_mask_t   served;
        logic [ID_W-1:0] grant;
        logic [ID_W-1:0] held_grant;
        logic            stalled;
        int              n;
        int              cyc;
        test_name  = "round_robin";
        served     = '0;
        held_grant = '0;
        stalled    = 1'b0;
        n          = 0;
        tick();
        for (int k = 0; k < NUM; k++) begin
            cluster_io_req[k] = random_req();
        end
        cluster_io_req_valid = '1;
        io_req_ready         = 1'b0;
        for (cyc = 0; cyc < TIMEOUT && n < NUM; cyc++) begin
            @(negedge clk);
            grant = io_req.tag[TAG_W +: ID_W];
            check_eq("io_req_valid", 64'(1), 64'(io_req_valid));
            if (stalled) begin
                check_eq("grant held under stall", 64'(held_grant), 64'(grant));
            end
            if (io_req_ready) begin
                check_eq("grant order", 64'(n), 64'(grant));
                check_eq("granted twice", 64'(0), 64'(served[grant]));
                check_eq("cluster ready", 64'(cluster_mask_t'(1) << grant),
                         64'(cluster_io_req_ready));
                served[grant] = 1'b1;
                n++;
                stalled = 1'b0;
            end else begin
                check_eq("cluster ready while stalled", 64'(0), 64'(cluster_io_req_ready));
                held_grant = grant;
                stalled    = 1'b1;
            end
            tick();
            // Every cluster keeps requesting, only the pointer moves the grant
            io_req_ready         = ~io_req_ready;
        end
        if (n < NUM) begin
            report_timeout("all four grants");
        end
        cluster_io_req_valid = '0;
        io_req_ready         = 1'b0;
        finish_test();
    endtask

    task automatic route_responses();
        io_rsp_out_t             rsp;
        logic [TAG_W-1:0]        core_tag;
        cluster_mask_t           ready_mask;
        test_name = "response_route";
        for (int k = 0; k < NUM; k++) begin
            core_tag = 8'($urandom);
            rsp.data = $urandom;
            rsp.tag  = {ID_W'(k), core_tag};
            // Stall first, then accept the same response
            for (int pass = 0; pass < 2; pass++) begin
                tick();
                io_rsp               = rsp;
                io_rsp_valid         = 1'b1;
                ready_mask           = 4'($urandom);
                ready_mask[k]        = (pass == 1);
                cluster_io_rsp_ready = ready_mask;
                @(negedge clk);
                check_eq("cluster valid", 64'(cluster_mask_t'(1) << k),
                         64'(cluster_io_rsp_valid));
                check_eq("stripped tag", 64'(core_tag), 64'(cluster_io_rsp.tag));
                check_eq("data", 64'(rsp.data), 64'(cluster_io_rsp.data));
                check_eq("io_rsp_ready", 64'(ready_mask[k]), 64'(io_rsp_ready));
            end
        end
        tick();
        io_rsp_valid         = 1'b0;
        cluster_io_rsp_ready = '0;
        finish_test();
    endtask

    task automatic broadcast_snoop();
        snp_req_t      req;
        int            fwd_wait [NUM];
        int            rsp_wait [NUM];
        int            fwd_count [NUM];
        cluster_mask_t answered;
        logic          done;
        int            cyc;
        test_name      = "snoop_broadcast";
        req.addr       = 26'($urandom);
        req.invalidate = 1'($urandom);
        req.tag        = 6'($urandom);
        answered       = '0;
        done           = 1'b0;
        for (int k = 0; k < NUM; k++) begin
            fwd_wait[k]  = $urandom_range(0, 4);
            rsp_wait[k]  = $urandom_range(0, 8);
            fwd_count[k] = 0;
        end
        tick();
        snp_req       = req;
        snp_req_valid = 1'b1;
        for (cyc = 0; cyc < TIMEOUT; cyc++) begin
            @(negedge clk);
            if (snp_req_ready) begin
                break;
            end
        end
        if (cyc == TIMEOUT) begin
            report_timeout("snp_req_ready");
        end
        for (cyc = 0; cyc < TIMEOUT && !done; cyc++) begin
            tick();
            snp_req_valid = 1'b0;
            for (int k = 0; k < NUM; k++) begin
                if (fwd_wait[k] > 0) begin
                    fwd_wait[k]--;
                end
                cluster_snp_req_ready[k] = (fwd_wait[k] == 0);
                // Answer some cycles after taking the forward
                cluster_snp_rsp_valid[k] = 1'b0;
                if (fwd_count[k] > 0 && !answered[k]) begin
                    if (rsp_wait[k] > 0) begin
                        rsp_wait[k]--;
                    end else begin
                        cluster_snp_rsp_valid[k] = 1'b1;
                    end
                end
            end
            snp_rsp_ready = 1'($urandom_range(0, 1));
            @(negedge clk);
            check_eq("snp_req_ready during snoop", 64'(0), 64'(snp_req_ready));
            check_eq("busy during snoop", 64'(1), 64'(busy));
            if (snp_rsp_valid) begin
                check_eq("answers before response", 64'(cluster_mask_t'('1)),
                         64'(answered));
                check_eq("snp_rsp_tag", 64'(req.tag), 64'(snp_rsp_tag));
                done = snp_rsp_ready;
            end
            // Only clusters still owing an answer are taken
            check_eq("response ready", 64'(cluster_mask_t'(~answered)),
                     64'(cluster_snp_rsp_ready));
            for (int k = 0; k < NUM; k++) begin
                if (cluster_snp_req_valid[k] && cluster_snp_req_ready[k]) begin
                    fwd_count[k]++;
                    check_eq("forwarded snoop", 64'(req), 64'(cluster_snp_req));
                end
                if (cluster_snp_rsp_valid[k] && cluster_snp_rsp_ready[k]) begin
                    answered[k] = 1'b1;
                end
            end
        end
        if (!done) begin
            report_timeout("snoop response");
        end
        for (int k = 0; k < NUM; k++) begin
            check_eq("forwards per cluster", 64'(1), 64'(fwd_count[k]));
        end
        tick();
        cluster_snp_req_ready = '0;
        cluster_snp_rsp_valid = '0;
        snp_rsp_ready         = 1'b0;
        @(negedge clk);
        check_eq("snp_req_ready after response", 64'(1), 64'(snp_req_ready));
        check_eq("snp_rsp_valid after response", 64'(0), 64'(snp_rsp_valid));
        check_eq("response ready after snoop", 64'(cluster_mask_t'('1)),
                 64'(cluster_snp_rsp_ready));
        check_eq("busy after snoop", 64'(0), 64'(busy));
        finish_test();
    endtask

    task automatic sweep_status();
        test_name = "status";
        for (int i = 0; i < 16; i++) begin
            tick();
            cluster_busy   = 4'(i);
            cluster_ebreak = 4'(i);
            @(negedge clk);
            check_eq("busy", 64'(i != 0), 64'(busy));
            check_eq("ebreak", 64'(i == 15), 64'(ebreak));
        end
        tick();
        cluster_busy   = '0;
        cluster_ebreak = '0;
        finish_test();
    endtask

    initial begin
        clk                   = 1'b0;
        reset                 = 1'b1;
        cluster_io_req_valid  = '0;
        cluster_io_req        = '0;
        cluster_io_rsp_ready  = '0;
        cluster_snp_req_ready = '0;
        cluster_snp_rsp_valid = '0;
        cluster_busy          = '0;
        cluster_ebreak        = '0;
        io_req_ready          = 1'b0;
        io_rsp_valid          = 1'b0;
        io_rsp                = '0;
        snp_req_valid         = 1'b0;
        snp_req               = '0;
        snp_rsp_ready         = 1'b0;
        test_errors           = 0;
        tests_passed          = 0;
        tests_failed          = 0;
        void'($urandom(32'h7278));

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        check_reset_state();
        drive_single_requests();
        exercise_round_robin();
        route_responses();
        broadcast_snoop();
        sweep_status();

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
design/fabric_pkg.sv
design/io_arbiter.sv
design/snoop_rsp_counter.sv
design/snoop_fwd_fsm.sv
design/vortex_fabric.sv
sim/fabric_assert.sv
sim/tb_vortex_fabric.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_vortex_fabric -o tb_vortex_fabric
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_vortex_fabric)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
